/* flist.f */
src/bse_pkg.sv
src/bse_apb_regs.sv
src/bse_state.sv
src/bse_serial_alu.sv
src/bse_top.sv
tb/bse_chk.sv
tb/bse_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module bse_tb \
   --Mdir obj_dir \
   -o bse_sim \
   -f flist.f

out=$(./obj_dir/bse_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Verification passed"; then
   exit 0
fi
exit 1

/* src/bse_apb_regs.sv */
`timescale 1ns/1ps

module bse_apb_regs (
   input  logic                           i_clk,
   input  logic                           i_rst,
   input  logic                           i_psel,
   input  logic                           i_penable,
   input  logic                           i_pwrite,
   input  logic [bse_pkg::BSE_APB_AW-1:0] i_paddr,
   input  logic [bse_pkg::BSE_XLEN-1:0]   i_pwdata,
   input  logic                           i_done,
   input  logic                           i_trap,
   input  logic [bse_pkg::BSE_XLEN-1:0]   i_result,
   output logic [bse_pkg::BSE_XLEN-1:0]   o_prdata,
   output logic                           o_pready,
   output logic                           o_pslverr,
   output logic                           o_irq,
   output logic                           o_start,
   output bse_pkg::bse_op_e               o_op,
   output logic [bse_pkg::BSE_XLEN-1:0]   o_opa,
   output logic [bse_pkg::BSE_XLEN-1:0]   o_opb
);
   import bse_pkg::*;

   logic                access;
   logic                sel_opa;
   logic                sel_opb;
   logic                sel_cmd;
   logic                sel_res;
   logic                sel_st;
   logic                mapped;
   logic                locked;
   logic                wr_ok;
   logic                busy;
   logic                done_f;
   logic                trap_f;
   logic                irq_en;
   logic                start_q;
   bse_op_e             op_q;
   logic [BSE_XLEN-1:0] opa_q;
   logic [BSE_XLEN-1:0] opb_q;
   logic [BSE_XLEN-1:0] result_q;

   // a transfer only takes effect in the access phase
   assign access = i_psel & i_penable;

   assign sel_opa = (i_paddr == REG_OPA);
   assign sel_opb = (i_paddr == REG_OPB);
   assign sel_cmd = (i_paddr == REG_CMD);
   assign sel_res = (i_paddr == REG_RESULT);
   assign sel_st  = (i_paddr == REG_STATUS);
   assign mapped  = sel_opa | sel_opb | sel_cmd | sel_res | sel_st;

   // operands and command are frozen while the engine is running
   assign locked = busy & (sel_opa | sel_opb | sel_cmd);
   assign wr_ok  = access & i_pwrite & mapped & !locked;

   // there are no wait states
   assign o_pready = 1'b1;
   // a refused write reports an error and leaves every register alone
   assign o_pslverr = access & (!mapped | (i_pwrite & locked));

   // read mux, unmapped offsets return zero
   always_comb begin
      o_prdata = '0;
      if (sel_opa) begin
         o_prdata = opa_q;
      end else if (sel_opb) begin
         o_prdata = opb_q;
      end else if (sel_cmd) begin
         o_prdata[CMD_OP_MSB:CMD_OP_LSB] = op_q;
         o_prdata[CMD_IRQ_EN]            = irq_en;
      end else if (sel_res) begin
         o_prdata = result_q;
      end else if (sel_st) begin
         o_prdata[ST_BUSY] = busy;
         o_prdata[ST_DONE] = done_f;
         o_prdata[ST_TRAP] = trap_f;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         opa_q    <= '0;
         opb_q    <= '0;
         result_q <= '0;
         op_q     <= OP_ADD;
         irq_en   <= 1'b0;
         busy     <= 1'b0;
         done_f   <= 1'b0;
         trap_f   <= 1'b0;
         start_q  <= 1'b0;
      end else begin
         // start is a single cycle strobe
         start_q <= 1'b0;
         if (wr_ok & sel_opa) begin
            opa_q <= i_pwdata;
         end
         if (wr_ok & sel_opb) begin
            opb_q <= i_pwdata;
         end
         // writing a one clears the matching sticky flag
         if (wr_ok & sel_st) begin
            if (i_pwdata[ST_DONE]) begin
               done_f <= 1'b0;
            end
            if (i_pwdata[ST_TRAP]) begin
               trap_f <= 1'b0;
            end
         end
         // an accepted command starts a new operation in the next cycle
         if (wr_ok & sel_cmd) begin
            op_q    <= bse_op_e'(i_pwdata[CMD_OP_MSB:CMD_OP_LSB]);
            irq_en  <= i_pwdata[CMD_IRQ_EN];
            start_q <= 1'b1;
            busy    <= 1'b1;
            done_f  <= 1'b0;
            trap_f  <= 1'b0;
         end
         // the result register only changes on a real completion
         if (i_done) begin
            result_q <= i_result;
            done_f   <= 1'b1;
            busy     <= 1'b0;
         end
         if (i_trap) begin
            trap_f <= 1'b1;
            busy   <= 1'b0;
         end
      end
   end

   // level interrupt follows the sticky flags while enabled
   assign o_irq = irq_en & (done_f | trap_f);

   assign o_start = start_q;
   assign o_op    = op_q;
   assign o_opa   = opa_q;
   assign o_opb   = opb_q;

endmodule

/* src/bse_pkg.sv */
package bse_pkg;

   // operand and result width of the serial engine
   localparam int BSE_XLEN = 32;

   // the bit position counter covers 0 to 31
   // its two low bits live in a one-hot ring inside the sequencer
   localparam int BSE_CNT_W = 5;

   // only the low five bits of operand b give the shift amount
   localparam int BSE_SHAMT_W = 5;

   // the apb address bus reaches up to the status register
   localparam int BSE_APB_AW = 5;

   // operation codes written to the command register
   // any code above OP_SRL makes the engine trap
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLT  = 4'd5,
      OP_SLTU = 4'd6,
      OP_SLL  = 4'd7,
      OP_SRL  = 4'd8
   } bse_op_e;

   // byte offsets of the register map
   localparam logic [BSE_APB_AW-1:0] REG_OPA    = 5'h00;
   localparam logic [BSE_APB_AW-1:0] REG_OPB    = 5'h04;
   localparam logic [BSE_APB_AW-1:0] REG_CMD    = 5'h08;
   localparam logic [BSE_APB_AW-1:0] REG_RESULT = 5'h0C;
   localparam logic [BSE_APB_AW-1:0] REG_STATUS = 5'h10;

   // fields of the command register
   localparam int CMD_OP_LSB = 0;
   localparam int CMD_OP_MSB = 3;
   localparam int CMD_IRQ_EN = 8;

   // bit positions in the status register
   // done and trap are write-one-to-clear
   localparam int ST_BUSY = 0;
   localparam int ST_DONE = 1;
   localparam int ST_TRAP = 2;

endpackage

/* src/bse_serial_alu.sv */
`timescale 1ns/1ps

module bse_serial_alu (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_load,
   input  logic                         i_cnt_en,
   input  logic                         i_init,
   input  logic                         i_shamt_en,
   input  logic                         i_sh_run,
   input  bse_pkg::bse_op_e             i_op,
   input  logic [bse_pkg::BSE_XLEN-1:0] i_opa,
   input  logic [bse_pkg::BSE_XLEN-1:0] i_opb,
   output logic                         o_sh_done,
   output logic [bse_pkg::BSE_XLEN-1:0] o_result
);
   import bse_pkg::*;

   logic [BSE_XLEN-1:0]    a_buf;
   logic [BSE_XLEN-1:0]    b_buf;
   logic [BSE_XLEN-1:0]    result_q;
   logic [BSE_SHAMT_W-1:0] shamt;
   logic                   carry;
   logic                   cmp;
   logic                   a_bit;
   logic                   b_bit;
   logic                   sub_like;
   logic                   b_eff;
   logic                   sum_bit;
   logic                   carry_nxt;
   logic                   lt_bit;
   logic                   run_en;
   logic                   res_bit;

   // both buffers present their lsb first
   assign a_bit = a_buf[0];
   assign b_bit = b_buf[0];

   // subtraction and compares add the inverted b with a carry in of one
   assign sub_like  = (i_op == OP_SUB) | (i_op == OP_SLT) | (i_op == OP_SLTU);
   assign b_eff     = b_bit ^ sub_like;
   assign sum_bit   = a_bit ^ b_eff ^ carry;
   assign carry_nxt = (a_bit & b_eff) | (a_bit & carry) | (b_eff & carry);

   // unsigned less than is a borrow out of the top bit
   // signed less than takes a's sign when the signs differ and the
   // sign of the difference otherwise
   // only the value left after bit 31 of the init pass is kept
   assign lt_bit = (i_op == OP_SLTU) ? !carry_nxt :
                   ((a_bit ^ b_bit) ? a_bit : sum_bit);

   // the run pass is every counting cycle outside the init pass
   assign run_en = i_cnt_en & !i_init;

   always_comb begin
      case (i_op)
         OP_ADD, OP_SUB: res_bit = sum_bit;
         OP_AND:         res_bit = a_bit & b_bit;
         OP_OR:          res_bit = a_bit | b_bit;
         OP_XOR:         res_bit = a_bit ^ b_bit;
         // the compare flag goes into bit 0 and is cleared behind it
         OP_SLT, OP_SLTU: res_bit = cmp;
         // shifted a simply streams out
         OP_SLL, OP_SRL: res_bit = a_bit;
         default:        res_bit = 1'b0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         a_buf    <= '0;
         b_buf    <= '0;
         result_q <= '0;
         shamt    <= '0;
         carry    <= 1'b0;
         cmp      <= 1'b0;
      end else begin
         // buffers rotate during a pass so they are intact for the next one
         if (i_load) begin
            a_buf <= i_opa;
            b_buf <= i_opb;
         end else if (i_cnt_en) begin
            a_buf <= {a_bit, a_buf[BSE_XLEN-1:1]};
            b_buf <= {b_bit, b_buf[BSE_XLEN-1:1]};
         end else if (i_sh_run) begin
            // one position per cycle of the shift interval with zero fill
            if (i_op == OP_SLL) begin
               a_buf <= {a_buf[BSE_XLEN-2:0], 1'b0};
            end else begin
               a_buf <= {1'b0, a_buf[BSE_XLEN-1:1]};
            end
         end

         // carry is preset whenever the counter is idle
         // that way every pass starts with the right carry in
         carry <= i_cnt_en ? carry_nxt : sub_like;

         if (i_cnt_en & i_init) begin
            cmp <= lt_bit;
         end else if (run_en) begin
            cmp <= 1'b0;
         end

         // b bits 0 to 4 enter at the top and end up in order
         if (i_shamt_en) begin
            shamt <= {b_bit, shamt[BSE_SHAMT_W-1:1]};
         end else if (i_sh_run) begin
            shamt <= shamt - 1'b1;
         end

         // result fills from the top so bit 0 lands last at position 0
         if (run_en) begin
            result_q <= {res_bit, result_q[BSE_XLEN-1:1]};
         end
      end
   end

   assign o_sh_done = (shamt == '0);
   assign o_result  = result_q;

endmodule

/* src/bse_state.sv */
`timescale 1ns/1ps

module bse_state (
   input  logic             i_clk,
   input  logic             i_rst,
   input  logic             i_start,
   input  bse_pkg::bse_op_e i_op,
   input  logic             i_sh_done,
   output logic             o_load,
   output logic             o_cnt_en,
   output logic             o_init,
   output logic             o_shamt_en,
   output logic             o_sh_run,
   output logic             o_done,
   output logic             o_trap
);
   import bse_pkg::*;

   // upper bits of the bit position count normally
   logic [BSE_CNT_W-1:2] cnt_hi;
   // the two low bits are a one-hot ring that wraps every four cycles
   logic [3:0]           cnt_r;
   logic                 cnt_done;
   logic                 stage_two_req;
   logic                 active;
   logic                 init_done;
   logic                 sh_phase;
   logic                 done_r;
   logic                 trap_r;
   logic                 legal;
   logic                 two_pass;
   logic                 shift_op;
   logic                 init_phase;
   logic                 cnt_req;
   logic                 cnt0to4;

   // sort the opcode into one pass, two pass and shift classes
   always_comb begin
      legal    = 1'b0;
      two_pass = 1'b0;
      shift_op = 1'b0;
      case (i_op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            legal = 1'b1;
         end
         OP_SLT, OP_SLTU: begin
            legal    = 1'b1;
            two_pass = 1'b1;
         end
         OP_SLL, OP_SRL: begin
            legal    = 1'b1;
            two_pass = 1'b1;
            shift_op = 1'b1;
         end
         default: begin
            legal = 1'b0;
         end
      endcase
   end

   // the counter runs whenever a bit is circulating in the ring
   assign o_cnt_en = |cnt_r;

   // the init pass is the first of two passes of a two pass operation
   assign init_phase = active & two_pass & !init_done;
   assign o_init     = o_cnt_en & init_phase;

   // positions 0 to 4 carry the shift amount bits of operand b
   assign cnt0to4    = (cnt_hi == 3'd0) | ((cnt_hi == 3'd1) & cnt_r[0]);
   assign o_shamt_en = o_init & cnt0to4;

   // legality is decided once on the start strobe
   assign o_load = i_start & legal;

   // the shift interval lasts until the shift amount counter hits zero
   assign o_sh_run = sh_phase & !i_sh_done;

   // either a fresh start or the stage two request kicks off a pass
   assign cnt_req = o_load | stage_two_req;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt_hi        <= '0;
         cnt_r         <= '0;
         cnt_done      <= 1'b0;
         stage_two_req <= 1'b0;
         active        <= 1'b0;
         init_done     <= 1'b0;
         sh_phase      <= 1'b0;
         done_r        <= 1'b0;
         trap_r        <= 1'b0;
      end else begin
         // upper count steps each time the ring wraps
         if (cnt_r[3]) begin
            cnt_hi <= cnt_hi + 1'b1;
         end
         // the request bit is shifted in while idle
         // the last position strobe blocks the wrap and so ends the pass
         cnt_r    <= {cnt_r[2:0], (cnt_r[3] & !cnt_done) | (cnt_req & !o_cnt_en)};
         // high during position 31
         cnt_done <= (cnt_hi == '1) & cnt_r[2];

         stage_two_req <= 1'b0;
         // a pass that is not the init pass writes the result
         done_r <= cnt_done & !init_phase;
         trap_r <= i_start & !legal;

         if (o_load) begin
            active    <= 1'b1;
            init_done <= 1'b0;
            sh_phase  <= 1'b0;
         end

         if (cnt_done) begin
            if (init_phase) begin
               init_done <= 1'b1;
               // compares go straight to the run pass after one idle cycle
               if (shift_op) begin
                  sh_phase <= 1'b1;
               end else begin
                  stage_two_req <= 1'b1;
               end
            end else begin
               active <= 1'b0;
            end
         end

         // shifts hand over to the run pass once the amount is used up
         if (sh_phase & i_sh_done) begin
            sh_phase      <= 1'b0;
            stage_two_req <= 1'b1;
         end
      end
   end

   assign o_done = done_r;
   assign o_trap = trap_r;

endmodule

/* src/bse_top.sv */
`timescale 1ns/1ps

module bse_top (
   input  logic                           i_clk,
   input  logic                           i_rst,
   input  logic                           i_psel,
   input  logic                           i_penable,
   input  logic                           i_pwrite,
   input  logic [bse_pkg::BSE_APB_AW-1:0] i_paddr,
   input  logic [bse_pkg::BSE_XLEN-1:0]   i_pwdata,
   output logic [bse_pkg::BSE_XLEN-1:0]   o_prdata,
   output logic                           o_pready,
   output logic                           o_pslverr,
   output logic                           o_irq
);
   import bse_pkg::*;

   // register block to sequencer and datapath
   logic                start;
   bse_op_e             op;
   logic [BSE_XLEN-1:0] opa;
   logic [BSE_XLEN-1:0] opb;
   // sequencer back to the register block
   logic                done;
   logic                trap;
   // sequencer to datapath and back
   logic                load;
   logic                cnt_en;
   logic                init;
   logic                shamt_en;
   logic                sh_run;
   logic                sh_done;
   logic [BSE_XLEN-1:0] result;

   bse_apb_regs u_regs (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .i_done    (done),
      .i_trap    (trap),
      .i_result  (result),
      .o_prdata  (o_prdata),
      .o_pready  (o_pready),
      .o_pslverr (o_pslverr),
      .o_irq     (o_irq),
      .o_start   (start),
      .o_op      (op),
      .o_opa     (opa),
      .o_opb     (opb)
   );

   bse_state u_state (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_start    (start),
      .i_op       (op),
      .i_sh_done  (sh_done),
      .o_load     (load),
      .o_cnt_en   (cnt_en),
      .o_init     (init),
      .o_shamt_en (shamt_en),
      .o_sh_run   (sh_run),
      .o_done     (done),
      .o_trap     (trap)
   );

   bse_serial_alu u_alu (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_load     (load),
      .i_cnt_en   (cnt_en),
      .i_init     (init),
      .i_shamt_en (shamt_en),
      .i_sh_run   (sh_run),
      .i_op       (op),
      .i_opa      (opa),
      .i_opb      (opb),
      .o_sh_done  (sh_done),
      .o_result   (result)
   );

endmodule

/* tb/bse_chk.sv */
`timescale 1ns/1ps

module bse_chk (
   input logic       i_clk,
   input logic       i_rst,
   input logic [3:0] i_ring,
   input logic       i_cnt_en,
   input logic       i_init,
   input logic       i_sh_run,
   input logic       i_load,
   input logic       i_done,
   input logic       i_trap
);

   // the low counter bits circulate as a single token or not at all
   a_ring_onehot: assert property (@(posedge i_clk) disable iff (i_rst) $onehot0(i_ring))
      else $error("sequencer ring holds more than one set bit");

   // an operation either completes or traps, never both
   a_done_trap: assert property (@(posedge i_clk) disable iff (i_rst) !(i_done && i_trap))
      else $error("done and trap strobes are high together");

   // the init pass begins with the first count of a pass and never partway through
   a_init_cnt: assert property (@(posedge i_clk) disable iff (i_rst)
                                $rose(i_init) |-> $rose(i_cnt_en))
      else $error("init rose while the counter was already running");

   // the shift interval sits between the passes
   a_shift_gap: assert property (@(posedge i_clk) disable iff (i_rst) !(i_sh_run && i_cnt_en))
      else $error("shift interval overlaps a counting pass");

   // a new operand load must not disturb a pass in flight
   a_load_idle: assert property (@(posedge i_clk) disable iff (i_rst) i_load |-> !i_cnt_en)
      else $error("operand load while the counter is running");

   // done follows the last position, once the ring has gone quiet
   a_done_idle: assert property (@(posedge i_clk) disable iff (i_rst) i_done |-> !i_cnt_en)
      else $error("done strobe while the counter is still running");

endmodule

bind bse_state bse_chk u_chk (
   .i_clk    (i_clk),
   .i_rst    (i_rst),
   .i_ring   (cnt_r),
   .i_cnt_en (o_cnt_en),
   .i_init   (o_init),
   .i_sh_run (o_sh_run),
   .i_load   (o_load),
   .i_done   (o_done),
   .i_trap   (o_trap)
);

/* tb/bse_tb.sv */
`timescale 1ns/1ps

module bse_tb;
   import bse_pkg::*;

   // half of the 8 ns clock period
   localparam int CLK_HALF = 4;
   // about 80 operations of at most 100 cycles each, plus their bus
   // accesses, stay far below this limit
   localparam int TIMEOUT_CYCLES = 20000;

   logic                  clk;
   logic                  rst;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [BSE_APB_AW-1:0] paddr;
   logic [BSE_XLEN-1:0]   pwdata;
   logic [BSE_XLEN-1:0]   prdata;
   logic                  pready;
   logic                  pslverr;
   logic                  irq;
   int                    errors = 0;
   int                    cycles = 0;
   integer                seed;

   bse_top u_dut (
      .i_clk     (clk),
      .i_rst     (rst),
      .i_psel    (psel),
      .i_penable (penable),
      .i_pwrite  (pwrite),
      .i_paddr   (paddr),
      .i_pwdata  (pwdata),
      .o_prdata  (prdata),
      .o_pready  (pready),
      .o_pslverr (pslverr),
      .o_irq     (irq)
   );

   always #CLK_HALF clk = ~clk;

   // a stuck engine would leave the status poll spinning forever
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Verification failed");
         $finish;
      end
   end

   task automatic report_mismatch(input string name, input logic [BSE_XLEN-1:0] expected,
                                  input logic [BSE_XLEN-1:0] actual);
      errors++;
      $display("mismatch %s: expected %h, got %h", name, expected, actual);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("error: %s", what);
   endtask

   // setup phase on one falling edge, access phase on the next
   task automatic apb_transfer(input logic write, input logic [BSE_APB_AW-1:0] addr,
                               input logic [BSE_XLEN-1:0] wdata,
                               output logic [BSE_XLEN-1:0] rdata, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = write;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      // the access phase outputs are combinational and settle well before the edge
      #1;
      if (!pready) begin
         report_failure("pready was low in the access phase");
      end
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [BSE_APB_AW-1:0] addr, input logic [BSE_XLEN-1:0] data,
                            output logic err);
      logic [BSE_XLEN-1:0] unused;
      apb_transfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apb_read(input logic [BSE_APB_AW-1:0] addr, output logic [BSE_XLEN-1:0] data,
                           output logic err);
      apb_transfer(1'b0, addr, '0, data, err);
   endtask

   // op code in the low nibble and interrupt enable in bit 8
   function automatic logic [BSE_XLEN-1:0] command_word(input logic [3:0] op, input logic irq_en);
      command_word = {23'd0, irq_en, 4'd0, op};
   endfunction

   // reference model of the engine, shift amount from b bits 4..0 only
   function automatic logic [BSE_XLEN-1:0] expected_result(input logic [3:0] op,
                                                           input logic [BSE_XLEN-1:0] a,
                                                           input logic [BSE_XLEN-1:0] b);
      logic [4:0] amt;
      amt = b[4:0];
      case (op)
         OP_ADD:  expected_result = a + b;
         OP_SUB:  expected_result = a - b;
         OP_AND:  expected_result = a & b;
         OP_OR:   expected_result = a | b;
         OP_XOR:  expected_result = a ^ b;
         OP_SLT:  expected_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         OP_SLTU: expected_result = (a < b) ? 32'd1 : 32'd0;
         OP_SLL:  expected_result = a << amt;
         OP_SRL:  expected_result = a >> amt;
         default: expected_result = '0;
      endcase
   endfunction

   // poll STATUS until busy falls and hand back the last value read
   task automatic wait_idle(output logic [BSE_XLEN-1:0] st);
      logic err;
      apb_read(REG_STATUS, st, err);
      while (st[ST_BUSY]) begin
         apb_read(REG_STATUS, st, err);
      end
   endtask

   task automatic run_op(input logic [3:0] op, input logic [BSE_XLEN-1:0] a,
                         input logic [BSE_XLEN-1:0] b, input logic irq_en,
                         output logic [BSE_XLEN-1:0] res);
      logic [BSE_XLEN-1:0] st;
      logic [BSE_XLEN-1:0] exp;
      logic                err;
      exp = expected_result(op, a, b);
      apb_write(REG_OPA, a, err);
      if (err) report_failure("pslverr on an OPA write while idle");
      apb_write(REG_OPB, b, err);
      if (err) report_failure("pslverr on an OPB write while idle");
      apb_write(REG_CMD, command_word(op, irq_en), err);
      if (err) report_failure("pslverr on a CMD write while idle");
      wait_idle(st);
      // done set, trap and busy clear
      if (st !== 32'h2) report_mismatch($sformatf("status op %0d", op), 32'h2, st);
      apb_read(REG_RESULT, res, err);
      if (res !== exp) report_mismatch($sformatf("result op %0d", op), exp, res);
   endtask

   task automatic check_reset_state();
      logic [BSE_XLEN-1:0] st;
      logic                err;
      apb_read(REG_STATUS, st, err);
      if (st !== 32'h0) report_mismatch("status after reset", 32'h0, st);
      if (irq !== 1'b0) report_failure("irq was high after reset");
   endtask

   task automatic test_one_pass();
      logic [3:0]          op;
      logic [BSE_XLEN-1:0] res;
      for (int i = 0; i < 5; i++) begin
         op = i[3:0];
         for (int k = 0; k < 8; k++) begin
            run_op(op, $random(seed), $random(seed), 1'b0, res);
         end
      end
      // wraparound at both ends of the range
      run_op(OP_ADD, 32'hffff_ffff, 32'h1, 1'b0, res);
      run_op(OP_SUB, 32'h0, 32'h1, 1'b0, res);
   endtask

   task automatic test_compare();
      logic [BSE_XLEN-1:0] a;
      logic [BSE_XLEN-1:0] b;
      logic [BSE_XLEN-1:0] r_s;
      logic [BSE_XLEN-1:0] r_u;
      for (int i = 0; i < 6; i++) begin
         a = $random(seed);
         b = $random(seed);
         // opposite sign bits make signed and unsigned order disagree
         b[31] = ~a[31];
         run_op(OP_SLT, a, b, 1'b0, r_s);
         run_op(OP_SLTU, a, b, 1'b0, r_u);
         if (r_s == r_u) report_failure("slt and sltu agreed on operands of opposite sign");
      end
      run_op(OP_SLT, 32'h8000_0000, 32'h1, 1'b0, r_s);
      run_op(OP_SLTU, 32'h8000_0000, 32'h1, 1'b0, r_u);
      run_op(OP_SLT, 32'h1, 32'hffff_ffff, 1'b0, r_s);
      run_op(OP_SLTU, 32'h1, 32'hffff_ffff, 1'b0, r_u);
      // equal and same-sign pairs
      run_op(OP_SLT, 32'h5, 32'h5, 1'b0, r_s);
      run_op(OP_SLTU, 32'hffff_ff00, 32'hffff_ffff, 1'b0, r_u);
   endtask

   task automatic test_shift();
      logic [4:0]          amts [4];
      logic [BSE_XLEN-1:0] r;
      logic [BSE_XLEN-1:0] b;
      logic [BSE_XLEN-1:0] res;
      amts = '{5'd0, 5'd1, 5'd17, 5'd31};
      for (int i = 0; i < 4; i++) begin
         // junk above bit 4 of b must not change the amount
         r = $random(seed);
         b = {r[31:5], amts[i]};
         run_op(OP_SLL, $random(seed), b, 1'b0, res);
         run_op(OP_SRL, $random(seed), b, 1'b0, res);
      end
   endtask

   task automatic test_illegal();
      logic [BSE_XLEN-1:0] prev;
      logic [BSE_XLEN-1:0] st;
      logic [BSE_XLEN-1:0] res;
      logic                err;
      run_op(OP_XOR, $random(seed), $random(seed), 1'b0, prev);
      apb_write(REG_CMD, command_word(4'hb, 1'b0), err);
      if (err) report_failure("pslverr on a CMD write with an illegal op");
      wait_idle(st);
      if (st !== 32'h4) report_mismatch("status after trap", 32'h4, st);
      apb_read(REG_RESULT, res, err);
      if (res !== prev) report_mismatch("result after trap", prev, res);
      apb_write(REG_STATUS, 32'h4, err);
      apb_read(REG_STATUS, st, err);
      if (st !== 32'h0) report_mismatch("status after trap clear", 32'h0, st);
   endtask

   task automatic test_bus_rules();
      logic [BSE_XLEN-1:0] a;
      logic [BSE_XLEN-1:0] b;
      logic [BSE_XLEN-1:0] st;
      logic [BSE_XLEN-1:0] res;
      logic                err;
      a = $random(seed);
      b = $random(seed);
      // the longest shift keeps the engine busy for the refused writes
      b[4:0] = 5'd31;
      apb_write(REG_OPA, a, err);
      apb_write(REG_OPB, b, err);
      apb_write(REG_CMD, command_word(OP_SLL, 1'b0), err);
      apb_write(REG_OPA, ~a, err);
      if (!err) report_failure("no pslverr on an OPA write while busy");
      apb_write(REG_CMD, command_word(OP_ADD, 1'b0), err);
      if (!err) report_failure("no pslverr on a CMD write while busy");
      apb_read(REG_STATUS, st, err);
      if (err) report_failure("pslverr on a STATUS read while busy");
      wait_idle(st);
      if (st !== 32'h2) report_mismatch("status after busy writes", 32'h2, st);
      apb_read(REG_RESULT, res, err);
      if (res !== expected_result(OP_SLL, a, b)) begin
         report_mismatch("result after busy writes", expected_result(OP_SLL, a, b), res);
      end
      apb_read(REG_OPA, res, err);
      if (res !== a) report_mismatch("opa after busy write", a, res);
      apb_read(5'h14, res, err);
      if (!err) report_failure("no pslverr on a read of an unmapped address");
      apb_write(5'h1c, 32'h0, err);
      if (!err) report_failure("no pslverr on a write to an unmapped address");
      apb_write(REG_STATUS, 32'h2, err);
      apb_read(REG_STATUS, st, err);
      if (st !== 32'h0) report_mismatch("status after done clear", 32'h0, st);
   endtask

   task automatic test_irq();
      logic [BSE_XLEN-1:0] res;
      logic                err;
      run_op(OP_ADD, $random(seed), $random(seed), 1'b1, res);
      if (irq !== 1'b1) report_failure("irq stayed low after a completion with irq enabled");
      apb_write(REG_STATUS, 32'h2, err);
      if (irq !== 1'b0) report_failure("irq stayed high after done was cleared");
      run_op(OP_OR, $random(seed), $random(seed), 1'b0, res);
      if (irq !== 1'b0) report_failure("irq rose although irq enable was clear");
      apb_write(REG_STATUS, 32'h2, err);
   endtask

   initial begin
      clk     = 1'b0;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      seed    = 32'hba14;
      repeat (2) @(negedge clk);
      rst = 1'b0;
      check_reset_state();
      test_one_pass();
      test_compare();
      test_shift();
      test_illegal();
      test_bus_rules();
      test_irq();
      $display("errors: %0d, cycles: %0d", errors, cycles);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
